// ==== Makefile ====
# Verilator build and run for the accelerator testbench

SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert
TOP       ?= acc_x_tb_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== acc_defines.svh ====
// Global sizes and encodings for the offload accelerator.
// Include this in any file that needs a width, the buffer depth or the opcode.

`ifndef ACC_DEFINES_SVH
`define ACC_DEFINES_SVH

// Operand and result width in bits
`define ACC_XLEN 32

// Register address width, x0 to x31
`define ACC_REG_W 5

// Raw instruction word width
`define ACC_INSTR_W 32

// Entries in the result FIFO, which is also the credit pool
`define ACC_RES_DEPTH 4

// custom-0 major opcode
`define ACC_OPCODE_CUSTOM0 7'b0001011

`endif

// ==== acc_pkg.sv ====
// Types shared by the accelerator blocks and the testbench.
// Import with acc_pkg::* inside a module body.

`default_nettype none

`include "acc_defines.svh"

package acc_pkg;

  // Operand or result word
  typedef logic [`ACC_XLEN-1:0] acc_data_t;

  // Destination register address
  typedef logic [`ACC_REG_W-1:0] acc_reg_t;

  // Instruction as offered on the q channel
  typedef logic [`ACC_INSTR_W-1:0] acc_instr_t;

  // One valid bit per source operand, bit 0 is rs1
  typedef logic [2:0] acc_rs_valid_t;

  // Operations, values match funct3
  typedef enum logic [2:0] {
    OP_MADD    = 3'd0,
    OP_MIN     = 3'd1,
    OP_MAX     = 3'd2,
    OP_POPCNT  = 3'd3,
    OP_ROTL    = 3'd4,
    OP_ABSDIFF = 3'd5
  } acc_op_e;

endpackage

`default_nettype wire

// ==== acc_x_decoder.sv ====
// Input side of the accelerator. Decodes q offers, checks operands and credits,
// gives the same-cycle k answer and hands accepted work to the pipeline.

`timescale 1ns/1ps
`default_nettype none

`include "acc_defines.svh"

module acc_x_decoder (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   q_valid_i,
  input  acc_pkg::acc_instr_t    q_instr_data_i,
  input  acc_pkg::acc_rs_valid_t q_rs_valid_i,
  input  acc_pkg::acc_data_t     q_rs1_i,
  input  acc_pkg::acc_data_t     q_rs2_i,
  input  acc_pkg::acc_data_t     q_rs3_i,
  output logic                   q_ready_o,
  output logic                   k_accept_o,
  output logic                   k_writeback_o,
  input  logic [2:0]             credit_count_i,
  input  logic [1:0]             pipe_busy_i,
  output logic                   issue_valid_o,
  output acc_pkg::acc_op_e       issue_op_o,
  output acc_pkg::acc_reg_t      issue_rd_o,
  output acc_pkg::acc_data_t     issue_rs1_o,
  output acc_pkg::acc_data_t     issue_rs2_o,
  output acc_pkg::acc_data_t     issue_rs3_o
);
  import acc_pkg::*;

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  acc_reg_t      rd;
  acc_op_e       op;
  logic          legal;
  acc_rs_valid_t rs_need;
  logic          operands_ok;
  logic          credit_ok;
  logic          q_fire;

  // R4-type fields
  assign opcode = q_instr_data_i[6:0];
  assign rd     = q_instr_data_i[11:7];
  assign funct3 = q_instr_data_i[14:12];
  assign funct7 = q_instr_data_i[31:25];

  assign legal = (opcode == `ACC_OPCODE_CUSTOM0) && (funct7 == 7'd0) && (funct3 <= 3'd5);
  assign op    = acc_op_e'(funct3);

  // Operands each operation reads; a rejected instruction reads none
  always_comb begin
    rs_need = 3'b000;
    if (legal) begin
      case (op)
        OP_MADD:   rs_need = 3'b111;
        OP_POPCNT: rs_need = 3'b001;
        default:   rs_need = 3'b011;
      endcase
    end
  end

  assign operands_ok = ((q_rs_valid_i & rs_need) == rs_need);

  // Free slots must cover everything already in flight plus this one
  assign credit_ok = (credit_count_i > {1'b0, pipe_busy_i});

  assign q_ready_o = operands_ok && (!legal || credit_ok);
  assign q_fire    = q_valid_i && q_ready_o;

  assign k_accept_o    = q_fire && legal;
  assign k_writeback_o = k_accept_o && (rd != '0);

  assign issue_valid_o = k_accept_o;
  assign issue_op_o    = op;
  assign issue_rd_o    = rd;
  assign issue_rs1_o   = q_rs1_i;
  assign issue_rs2_o   = q_rs2_i;
  assign issue_rs3_o   = q_rs3_i;

  // An issue lands in the pipeline next cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    issue_valid_o |=> (pipe_busy_i != 2'd0));

endmodule

`default_nettype wire

// ==== acc_x_exec.sv ====
// Two-stage execution pipeline. Stage 1 forms the product or the final value,
// stage 2 finishes MADD and flags signed overflow. Never stalls.

`timescale 1ns/1ps
`default_nettype none

`include "acc_defines.svh"

module acc_x_exec (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               issue_valid_i,
  input  acc_pkg::acc_op_e   issue_op_i,
  input  acc_pkg::acc_reg_t  issue_rd_i,
  input  acc_pkg::acc_data_t issue_rs1_i,
  input  acc_pkg::acc_data_t issue_rs2_i,
  input  acc_pkg::acc_data_t issue_rs3_i,
  output logic [1:0]         pipe_busy_o,
  output logic               res_valid_o,
  output acc_pkg::acc_reg_t  res_rd_o,
  output acc_pkg::acc_data_t res_data_o,
  output logic               res_error_o
);
  import acc_pkg::*;

  localparam int WIDE_W = 2 * `ACC_XLEN;

  logic                     s1_valid;
  acc_op_e                  s1_op;
  acc_reg_t                 s1_rd;
  logic [WIDE_W-1:0]        s1_value;
  acc_data_t                s1_rs3;
  logic                     s2_valid;
  acc_reg_t                 s2_rd;
  acc_data_t                s2_data;
  logic                     s2_error;

  logic signed [WIDE_W-1:0] product;
  logic [WIDE_W-1:0]        rotl_wide;
  logic                     rs1_lt_rs2;
  acc_data_t                absdiff_val;
  logic [WIDE_W-1:0]        stage1_value;
  logic signed [WIDE_W-1:0] madd_sum;
  logic                     madd_ovf;

  function automatic acc_data_t popcount(input acc_data_t value);
    acc_data_t count;
    count = '0;
    for (int i = 0; i < `ACC_XLEN; i++) begin
      count = count + acc_data_t'(value[i]);
    end
    return count;
  endfunction

  // Stage 1
  assign product     = $signed(issue_rs1_i) * $signed(issue_rs2_i);
  assign rotl_wide   = {issue_rs1_i, issue_rs1_i} << issue_rs2_i[4:0];
  assign rs1_lt_rs2  = ($signed(issue_rs1_i) < $signed(issue_rs2_i));
  assign absdiff_val = rs1_lt_rs2 ? (issue_rs2_i - issue_rs1_i) : (issue_rs1_i - issue_rs2_i);

  always_comb begin
    stage1_value = '0;
    case (issue_op_i)
      OP_MADD:    stage1_value = product;
      OP_MIN:     stage1_value[`ACC_XLEN-1:0] = rs1_lt_rs2 ? issue_rs1_i : issue_rs2_i;
      OP_MAX:     stage1_value[`ACC_XLEN-1:0] = rs1_lt_rs2 ? issue_rs2_i : issue_rs1_i;
      OP_POPCNT:  stage1_value[`ACC_XLEN-1:0] = popcount(issue_rs1_i);
      OP_ROTL:    stage1_value[`ACC_XLEN-1:0] = rotl_wide[WIDE_W-1:`ACC_XLEN];
      OP_ABSDIFF: stage1_value[`ACC_XLEN-1:0] = absdiff_val;
      default:    stage1_value = '0;
    endcase
  end

  // Stage 2, exact sum fits in 64 bits so overflow is a sign-bit mismatch
  assign madd_sum = $signed(s1_value) + $signed({{`ACC_XLEN{s1_rs3[`ACC_XLEN-1]}}, s1_rs3});
  assign madd_ovf = !((&madd_sum[WIDE_W-1:`ACC_XLEN-1]) || !(|madd_sum[WIDE_W-1:`ACC_XLEN-1]));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid_i;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op    <= issue_op_i;
    s1_rd    <= issue_rd_i;
    s1_value <= stage1_value;
    s1_rs3   <= issue_rs3_i;
    s2_rd    <= s1_rd;
    if (s1_op == OP_MADD) begin
      s2_data  <= madd_sum[`ACC_XLEN-1:0];
      s2_error <= madd_ovf;
    end else begin
      s2_data  <= s1_value[`ACC_XLEN-1:0];
      s2_error <= 1'b0;
    end
  end

  assign pipe_busy_o = {1'b0, s1_valid} + {1'b0, s2_valid};
  assign res_valid_o = s2_valid;
  assign res_rd_o    = s2_rd;
  assign res_data_o  = s2_data;
  assign res_error_o = s2_error;

  // Error flag traces back to a MADD issued two cycles earlier
  assert property (@(posedge clk_i) disable iff (rst_i)
    (res_valid_o && res_error_o) |-> ($past(issue_op_i, 2) == OP_MADD));

endmodule

`default_nettype wire

// ==== acc_x_result_buf.sv ====
// In-order result FIFO feeding the p channel.
// Free entries go back to the decoder as credits.

`timescale 1ns/1ps
`default_nettype none

`include "acc_defines.svh"

module acc_x_result_buf (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               res_valid_i,
  input  acc_pkg::acc_reg_t  res_rd_i,
  input  acc_pkg::acc_data_t res_data_i,
  input  logic               res_error_i,
  output logic               p_valid_o,
  input  logic               p_ready_i,
  output acc_pkg::acc_reg_t  p_rd_o,
  output acc_pkg::acc_data_t p_data_o,
  output logic               p_error_o,
  output logic [2:0]         credit_count_o
);
  import acc_pkg::*;

  localparam int PTR_W = $clog2(`ACC_RES_DEPTH);

  acc_reg_t         rd_mem   [`ACC_RES_DEPTH];
  acc_data_t        data_mem [`ACC_RES_DEPTH];
  logic             err_mem  [`ACC_RES_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [2:0]       count;
  logic             push;
  logic             pop;
  logic             full;

  assign push = res_valid_i;
  assign pop  = p_valid_o && p_ready_i;
  assign full = (count == 3'(`ACC_RES_DEPTH));

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      rd_mem[wr_ptr]   <= res_rd_i;
      data_mem[wr_ptr] <= res_data_i;
      err_mem[wr_ptr]  <= res_error_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`ACC_RES_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`ACC_RES_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 3'd1;
        2'b01:   count <= count - 3'd1;
        default: count <= count;
      endcase
    end
  end

  // Head of queue drives p directly
  assign p_valid_o      = (count != 3'd0);
  assign p_rd_o         = rd_mem[rd_ptr];
  assign p_data_o       = data_mem[rd_ptr];
  assign p_error_o      = err_mem[rd_ptr];
  assign credit_count_o = 3'(`ACC_RES_DEPTH) - count;

  // Upstream credit check must keep results from arriving at a full buffer
  assert property (@(posedge clk_i) disable iff (rst_i) res_valid_i |-> !full);

  // Stalled p holds its offer
  assert property (@(posedge clk_i) disable iff (rst_i)
    (p_valid_o && !p_ready_i) |=>
      (p_valid_o && $stable(p_rd_o) && $stable(p_data_o) && $stable(p_error_o)));

endmodule

`default_nettype wire

// ==== acc_x_tb_top.sv ====
// Testbench for the accelerator. Plays the core on q, k and p with random
// instructions from a fixed seed and checks every result against a model.

`timescale 1ns/1ps
`default_nettype none

`include "acc_defines.svh"

module acc_x_tb_top;
  import acc_pkg::*;

  localparam int     CLK_HALF       = 20;
  localparam int     NUM_INSTR      = 300;
  localparam int     TIMEOUT_CYCLES = 20 * NUM_INSTR + 100;
  localparam longint INT_MAX        = 64'sd2147483647;
  localparam longint INT_MIN        = -64'sd2147483648;

  logic          clk;
  logic          rst_i;
  logic          q_valid_i;
  logic          q_ready_o;
  acc_instr_t    q_instr_data_i;
  acc_data_t     q_rs1_i;
  acc_data_t     q_rs2_i;
  acc_data_t     q_rs3_i;
  acc_rs_valid_t q_rs_valid_i;
  logic          k_accept_o;
  logic          k_writeback_o;
  logic          p_valid_o;
  logic          p_ready_i;
  acc_reg_t      p_rd_o;
  acc_data_t     p_data_o;
  logic          p_error_o;

  integer        seed;
  int            errors;
  int            issued;
  int            accepted;
  int            returned;
  int            step_count;
  int            cycle_count = 0;
  logic          offer_pending;
  logic          seen_accept;
  logic          p_held;
  acc_reg_t      held_rd;
  acc_data_t     held_data;
  logic          held_err;

  // Expected results in q-transfer order
  acc_reg_t      exp_rd_q[$];
  acc_data_t     exp_data_q[$];
  logic          exp_err_q[$];

  acc_x_top acc_x_top_inst (
    .clk_i          (clk),
    .rst_i          (rst_i),
    .q_valid_i      (q_valid_i),
    .q_ready_o      (q_ready_o),
    .q_instr_data_i (q_instr_data_i),
    .q_rs1_i        (q_rs1_i),
    .q_rs2_i        (q_rs2_i),
    .q_rs3_i        (q_rs3_i),
    .q_rs_valid_i   (q_rs_valid_i),
    .k_accept_o     (k_accept_o),
    .k_writeback_o  (k_writeback_o),
    .p_valid_o      (p_valid_o),
    .p_ready_i      (p_ready_i),
    .p_rd_o         (p_rd_o),
    .p_data_o       (p_data_o),
    .p_error_o      (p_error_o)
  );

  always #CLK_HALF clk = ~clk;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Mix of full-range, small signed and near-extreme values
  function automatic acc_data_t make_operand();
    logic [31:0] mode;
    logic [31:0] r;
    mode = rand32();
    r    = rand32();
    if (mode[1:0] == 2'd2) begin
      return {{20{r[11]}}, r[11:0]};
    end else if (mode[1:0] == 2'd3) begin
      return {r[31], {15{~r[31]}}, r[15:0]};
    end
    return r;
  endfunction

  function automatic logic is_legal(input acc_instr_t instr);
    return (instr[6:0] == `ACC_OPCODE_CUSTOM0) && (instr[31:25] == 7'd0) &&
           (instr[14:12] <= 3'd5);
  endfunction

  function automatic acc_rs_valid_t needed_operands(input acc_instr_t instr);
    if (!is_legal(instr)) begin
      return 3'b000;
    end
    case (instr[14:12])
      3'd0:    return 3'b111;
      3'd3:    return 3'b001;
      default: return 3'b011;
    endcase
  endfunction

  function automatic void model_result(input logic [2:0] funct3, input acc_data_t rs1,
                                       input acc_data_t rs2, input acc_data_t rs3,
                                       output acc_data_t data, output logic err);
    int         a;
    int         b;
    int         c;
    logic [4:0] sh;
    longint     wide;
    a    = rs1;
    b    = rs2;
    c    = rs3;
    sh   = rs2[4:0];
    err  = 1'b0;
    data = '0;
    case (acc_op_e'(funct3))
      OP_MADD: begin
        wide = longint'(a) * longint'(b) + longint'(c);
        data = wide[31:0];
        err  = (wide > INT_MAX) || (wide < INT_MIN);
      end
      OP_MIN:    data = (a < b) ? rs1 : rs2;
      OP_MAX:    data = (a < b) ? rs2 : rs1;
      OP_POPCNT: data = $countones(rs1);
      OP_ROTL:   data = (rs1 << sh) | (rs1 >> (6'd32 - {1'b0, sh}));
      OP_ABSDIFF: begin
        wide = longint'(a) - longint'(b);
        if (wide < 0) begin
          wide = -wide;
        end
        data = wide[31:0];
      end
      default:   data = '0;
    endcase
  endfunction

  // Valid ops most of the time, plus bad opcode, funct3 6 or 7, nonzero funct7
  task automatic new_offer();
    logic [31:0] r;
    logic [31:0] r2;
    logic [3:0]  kind;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    r      = rand32();
    r2     = rand32();
    kind   = r[3:0] % 4'd10;
    opcode = `ACC_OPCODE_CUSTOM0;
    funct3 = (r[6:4] > 3'd5) ? r[6:4] - 3'd4 : r[6:4];
    funct7 = 7'd0;
    if (kind == 4'd7) begin
      opcode = (r[14:8] == `ACC_OPCODE_CUSTOM0) ? r[14:8] ^ 7'h40 : r[14:8];
    end else if (kind == 4'd8) begin
      funct3 = {2'b11, r[8]};
    end else if (kind == 4'd9) begin
      funct7 = r[15:9] | 7'd1;
    end
    q_instr_data_i = {funct7, r[25:16], funct3, r[30:26], opcode};
    q_rs1_i        = make_operand();
    q_rs2_i        = make_operand();
    q_rs3_i        = make_operand();
    q_rs_valid_i   = r2[3] ? 3'b111 : r2[2:0];
    offer_pending  = 1'b1;
  endtask

  task automatic check_p_channel();
    acc_reg_t  e_rd;
    acc_data_t e_data;
    logic      e_err;
    if (p_held) begin
      assert (p_valid_o) else begin
        $display("p_valid dropped at %0t while the core was stalling p", $time);
        errors++;
      end
      assert (p_rd_o == held_rd && p_data_o == held_data && p_error_o == held_err) else begin
        $display("FAIL %0t: p outputs changed while stalled", $time);
        errors++;
      end
    end
    if (p_valid_o) begin
      assert (seen_accept) else begin
        $display("p_valid went high at %0t before any instruction was accepted", $time);
        errors++;
      end
    end
    if (p_valid_o && p_ready_i) begin
      assert (exp_data_q.size() != 0) else begin
        $display("A result came back at %0t with nothing outstanding", $time);
        errors++;
      end
      if (exp_data_q.size() != 0) begin
        e_rd   = exp_rd_q.pop_front();
        e_data = exp_data_q.pop_front();
        e_err  = exp_err_q.pop_front();
        assert (p_rd_o == e_rd && p_data_o == e_data && p_error_o == e_err) else begin
          $display("FAIL %0t: p rd %0d data %h err %b, expected rd %0d data %h err %b",
                   $time, p_rd_o, p_data_o, p_error_o, e_rd, e_data, e_err);
          errors++;
        end
        returned++;
      end
    end
    p_held    = p_valid_o && !p_ready_i;
    held_rd   = p_rd_o;
    held_data = p_data_o;
    held_err  = p_error_o;
  endtask

  // Drive on the falling edge, sample a quarter period before the rising edge
  task automatic run_cycle();
    logic [31:0]   r;
    logic          fire;
    logic          legal;
    acc_rs_valid_t need;
    acc_data_t     e_data;
    logic          e_err;
    int            outstanding;
    logic          exp_ready;
    @(negedge clk);
    step_count++;
    r = rand32();
    if (!offer_pending && issued < NUM_INSTR && r[1:0] != 2'b00) begin
      new_offer();
    end else if (offer_pending) begin
      // Operands arrive over later cycles
      q_rs_valid_i = q_rs_valid_i | r[4:2];
    end
    q_valid_i = offer_pending;
    // Long stall windows on p, otherwise ready three times in four
    p_ready_i = ((step_count % 64) < 24) ? 1'b0 : (r[5] | r[6]);
    #(CLK_HALF / 2);

    // Results still in the pipeline or the buffer before this edge's pop
    outstanding = exp_data_q.size();
    check_p_channel();
    fire  = q_valid_i && q_ready_o;
    legal = is_legal(q_instr_data_i);
    need  = needed_operands(q_instr_data_i);
    if (q_valid_i) begin
      exp_ready = ((q_rs_valid_i & need) == need) &&
                  (!legal || outstanding < `ACC_RES_DEPTH);
      assert (q_ready_o == exp_ready) else begin
        $display("FAIL %0t: q_ready %b, expected %b with %0d outstanding",
                 $time, q_ready_o, exp_ready, outstanding);
        errors++;
      end
    end
    if (!fire) begin
      assert (!k_accept_o && !k_writeback_o) else begin
        $display("FAIL %0t: k answer active without a q transfer", $time);
        errors++;
      end
    end else begin
      assert ((q_rs_valid_i & need) == need) else begin
        $display("FAIL %0t: q transfer with rs_valid %b, needs %b", $time, q_rs_valid_i, need);
        errors++;
      end
      assert (k_accept_o == legal) else begin
        $display("FAIL %0t: k_accept %b, expected %b", $time, k_accept_o, legal);
        errors++;
      end
      assert (k_writeback_o == (legal && q_instr_data_i[11:7] != 5'd0)) else begin
        $display("FAIL %0t: k_writeback %b for rd %0d", $time, k_writeback_o,
                 q_instr_data_i[11:7]);
        errors++;
      end
      if (legal) begin
        model_result(q_instr_data_i[14:12], q_rs1_i, q_rs2_i, q_rs3_i, e_data, e_err);
        exp_rd_q.push_back(q_instr_data_i[11:7]);
        exp_data_q.push_back(e_data);
        exp_err_q.push_back(e_err);
        accepted++;
        seen_accept = 1'b1;
      end
      issued++;
      offer_pending = 1'b0;
    end
    assert (exp_data_q.size() <= `ACC_RES_DEPTH) else begin
      $display("More than %0d results outstanding at %0t", `ACC_RES_DEPTH, $time);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions issued",
               cycle_count, issued, NUM_INSTR);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    clk            = 1'b0;
    rst_i          = 1'b1;
    q_valid_i      = 1'b0;
    q_instr_data_i = '0;
    q_rs1_i        = '0;
    q_rs2_i        = '0;
    q_rs3_i        = '0;
    q_rs_valid_i   = '0;
    p_ready_i      = 1'b0;
    seed           = 32'h6593;
    errors         = 0;
    issued         = 0;
    accepted       = 0;
    returned       = 0;
    step_count     = 0;
    offer_pending  = 1'b0;
    seen_accept    = 1'b0;
    p_held         = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    while (issued < NUM_INSTR || exp_data_q.size() != 0) begin
      run_cycle();
    end
    // Idle tail, nothing more may come back
    repeat (8) run_cycle();

    $display("Done: %0d errors, %0d issued, %0d accepted, %0d returned, %0d left",
             errors, issued, accepted, returned, exp_data_q.size());
    if (errors == 0 && exp_data_q.size() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== acc_x_top.sv ====
// Accelerator top level for the core's extension port.
// q and k on the input side, p on the return side.

`timescale 1ns/1ps
`default_nettype none

module acc_x_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   q_valid_i,
  output logic                   q_ready_o,
  input  acc_pkg::acc_instr_t    q_instr_data_i,
  input  acc_pkg::acc_data_t     q_rs1_i,
  input  acc_pkg::acc_data_t     q_rs2_i,
  input  acc_pkg::acc_data_t     q_rs3_i,
  input  acc_pkg::acc_rs_valid_t q_rs_valid_i,
  output logic                   k_accept_o,
  output logic                   k_writeback_o,
  output logic                   p_valid_o,
  input  logic                   p_ready_i,
  output acc_pkg::acc_reg_t      p_rd_o,
  output acc_pkg::acc_data_t     p_data_o,
  output logic                   p_error_o
);
  import acc_pkg::*;

  logic       issue_valid;
  acc_op_e    issue_op;
  acc_reg_t   issue_rd;
  acc_data_t  issue_rs1;
  acc_data_t  issue_rs2;
  acc_data_t  issue_rs3;
  logic [1:0] pipe_busy;
  logic       res_valid;
  acc_reg_t   res_rd;
  acc_data_t  res_data;
  logic       res_error;
  logic [2:0] credit_count;

  acc_x_decoder u_decoder (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .q_valid_i      (q_valid_i),
    .q_instr_data_i (q_instr_data_i),
    .q_rs_valid_i   (q_rs_valid_i),
    .q_rs1_i        (q_rs1_i),
    .q_rs2_i        (q_rs2_i),
    .q_rs3_i        (q_rs3_i),
    .q_ready_o      (q_ready_o),
    .k_accept_o     (k_accept_o),
    .k_writeback_o  (k_writeback_o),
    .credit_count_i (credit_count),
    .pipe_busy_i    (pipe_busy),
    .issue_valid_o  (issue_valid),
    .issue_op_o     (issue_op),
    .issue_rd_o     (issue_rd),
    .issue_rs1_o    (issue_rs1),
    .issue_rs2_o    (issue_rs2),
    .issue_rs3_o    (issue_rs3)
  );

  acc_x_exec u_exec (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid),
    .issue_op_i    (issue_op),
    .issue_rd_i    (issue_rd),
    .issue_rs1_i   (issue_rs1),
    .issue_rs2_i   (issue_rs2),
    .issue_rs3_i   (issue_rs3),
    .pipe_busy_o   (pipe_busy),
    .res_valid_o   (res_valid),
    .res_rd_o      (res_rd),
    .res_data_o    (res_data),
    .res_error_o   (res_error)
  );

  acc_x_result_buf u_result_buf (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .res_valid_i    (res_valid),
    .res_rd_i       (res_rd),
    .res_data_i     (res_data),
    .res_error_i    (res_error),
    .p_valid_o      (p_valid_o),
    .p_ready_i      (p_ready_i),
    .p_rd_o         (p_rd_o),
    .p_data_o       (p_data_o),
    .p_error_o      (p_error_o),
    .credit_count_o (credit_count)
  );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
acc_pkg.sv
acc_x_decoder.sv
acc_x_exec.sv
acc_x_result_buf.sv
acc_x_top.sv
acc_x_tb_top.sv
